// File: rtl/buf_cfg_pkg.sv
`default_nettype none

// Sizing of the shared NPU buffer system
package buf_cfg_pkg;

  localparam int NUM_BUFS    = 6;  // IOB0, IOB1, WB, WIB, LSTMB, INSTB/BIASB style banks
  localparam int BANK_IDX_W  = 3;
  localparam int WORD_ADDR_W = 6;
  localparam int DATA_W      = 64;
  localparam int STRB_W      = DATA_W / 8;

  // Host sees bank index above word address
  localparam int HOST_ADDR_W = BANK_IDX_W + WORD_ADDR_W;
  localparam int NUM_WORDS   = 1 << WORD_ADDR_W;

  typedef logic [BANK_IDX_W-1:0]  bank_idx_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [HOST_ADDR_W-1:0] host_addr_t;
  typedef logic [DATA_W-1:0]      buf_data_t;
  typedef logic [STRB_W-1:0]      buf_strb_t;

endpackage

`default_nettype wire

// File: rtl/buf_bus_pkg.sv
`default_nettype none

// Request and tag formats passed between the buffer modules
package buf_bus_pkg;

  import buf_cfg_pkg::*;

  // Bank side request for one buffer bank
  typedef struct packed {
    logic       cs;     // Chip select for one cycle per request
    logic       we;     // Write when set, read otherwise
    word_addr_t addr;
    buf_data_t  wdata;
    buf_strb_t  strb;   // One bit per byte lane
  } buf_req_t;

  // Host side request with the flat address
  typedef struct packed {
    logic       cs;
    logic       we;
    host_addr_t addr;   // Bank index over word address
    buf_data_t  wdata;
    buf_strb_t  strb;
  } host_req_t;

  // Follows a host request to the return stage
  typedef struct packed {
    logic      rvalid;  // Host read to a real bank
    logic      err;     // Bank index out of range
    bank_idx_t bank;
  } rd_tag_t;

endpackage

`default_nettype wire

// File: rtl/buf_addr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module buf_addr_decode (
  input  buf_bus_pkg::host_req_t i_host_req,
  output buf_bus_pkg::buf_req_t  o_bank_req [buf_cfg_pkg::NUM_BUFS],
  output buf_bus_pkg::rd_tag_t   o_rd_tag
);

  import buf_cfg_pkg::*;
  import buf_bus_pkg::*;

  bank_idx_t  bank_idx;
  word_addr_t word_addr;
  logic       in_range;

  assign {bank_idx, word_addr} = i_host_req.addr;

  // Index 6 and 7 hit no bank
  assign in_range = (int'(bank_idx) < NUM_BUFS);

  // Fan out to the addressed bank only
  always_comb begin
    for (int i = 0; i < NUM_BUFS; i++) begin
      o_bank_req[i].cs    = i_host_req.cs && in_range && (bank_idx == bank_idx_t'(i));
      o_bank_req[i].we    = i_host_req.we;
      o_bank_req[i].addr  = word_addr;
      o_bank_req[i].wdata = i_host_req.wdata;
      o_bank_req[i].strb  = i_host_req.strb;
    end
  end

  // Tag for the return stage
  always_comb begin
    o_rd_tag.rvalid = i_host_req.cs && !i_host_req.we && in_range;
    o_rd_tag.err    = i_host_req.cs && !in_range;  // Reads and writes alike
    o_rd_tag.bank   = bank_idx;
  end

endmodule

`default_nettype wire

// File: rtl/buf_bank.sv
`timescale 1ns/100ps
`default_nettype none

module buf_bank (
  input  logic                   xclk,
  input  logic                   i_arst_n,
  input  logic                   i_host_en,   // High gives the bank to the host side
  input  buf_bus_pkg::buf_req_t  i_host_req,
  input  buf_bus_pkg::buf_req_t  i_eng_req,
  output buf_cfg_pkg::buf_data_t o_rdata
);

  import buf_cfg_pkg::*;
  import buf_bus_pkg::*;

  buf_req_t  sel_req;
  buf_data_t mem [NUM_WORDS];
  logic      wr_en;
  logic      rd_en;

  // Only the owning side's request goes through
  assign sel_req = i_host_en ? i_host_req : i_eng_req;

  assign wr_en = sel_req.cs && sel_req.we;
  assign rd_en = sel_req.cs && !sel_req.we;

  // Byte lane writes at the accepting edge
  always_ff @(posedge xclk) begin
    if (wr_en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (sel_req.strb[b]) begin
          mem[sel_req.addr][b*8 +: 8] <= sel_req.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read data holds until the next read
  always_ff @(posedge xclk) begin
    if (rd_en) begin
      o_rdata <= mem[sel_req.addr];
    end
  end

  // Decoder drives host requests only while the host owns the buffers
  a_host_owns: assert property (
    @(posedge xclk) disable iff (!i_arst_n)
    i_host_req.cs |-> i_host_en
  ) else $error("buf_bank: host request while engine owns the bank");

  // A write that touches no byte is a broken request
  a_wr_strb: assert property (
    @(posedge xclk) disable iff (!i_arst_n)
    wr_en |-> (sel_req.strb != '0)
  ) else $error("buf_bank: write with empty strobe");

endmodule

`default_nettype wire

// File: rtl/buf_read_return.sv
`timescale 1ns/100ps
`default_nettype none

module buf_read_return (
  input  logic                   xclk,
  input  logic                   i_arst_n,
  input  buf_bus_pkg::rd_tag_t   i_rd_tag,
  input  buf_cfg_pkg::buf_data_t i_bank_rdata [buf_cfg_pkg::NUM_BUFS],
  output buf_cfg_pkg::buf_data_t o_host_rdata,
  output logic                   o_host_rvalid,
  output logic                   o_host_err
);

  import buf_cfg_pkg::*;
  import buf_bus_pkg::*;

  rd_tag_t tag_q;

  // Tag lines up with the bank read register
  always_ff @(posedge xclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      tag_q <= '0;
    end else begin
      tag_q <= i_rd_tag;
    end
  end

  assign o_host_rvalid = tag_q.rvalid;  // One cycle pulse
  assign o_host_err    = tag_q.err;

  // Zero for indices past the last bank
  always_comb begin
    o_host_rdata = '0;
    for (int i = 0; i < NUM_BUFS; i++) begin
      if (tag_q.bank == bank_idx_t'(i)) begin
        o_host_rdata = i_bank_rdata[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/npu_buf_sys.sv
`timescale 1ns/100ps
`default_nettype none

module npu_buf_sys (
  input  logic                   xclk,
  input  logic                   i_arst_n,
  input  logic                   i_host_en,
  input  buf_bus_pkg::host_req_t i_host_req,
  output buf_cfg_pkg::buf_data_t o_host_rdata,
  output logic                   o_host_rvalid,
  output logic                   o_host_err,
  input  buf_bus_pkg::buf_req_t  i_eng_req   [buf_cfg_pkg::NUM_BUFS],
  output buf_cfg_pkg::buf_data_t o_eng_rdata [buf_cfg_pkg::NUM_BUFS]
);

  import buf_cfg_pkg::*;
  import buf_bus_pkg::*;

  buf_req_t  bank_req   [NUM_BUFS];  // Host side requests per bank
  rd_tag_t   rd_tag;
  buf_data_t bank_rdata [NUM_BUFS];

  // Flat host address to bank requests
  buf_addr_decode u_buf_addr_decode (
    .i_host_req (i_host_req),
    .o_bank_req (bank_req),
    .o_rd_tag   (rd_tag)
  );

  // All banks are identical
  for (genvar g = 0; g < NUM_BUFS; g++) begin : g_bank
    buf_bank u_buf_bank (
      .xclk       (xclk),
      .i_arst_n   (i_arst_n),
      .i_host_en  (i_host_en),
      .i_host_req (bank_req[g]),
      .i_eng_req  (i_eng_req[g]),
      .o_rdata    (bank_rdata[g])
    );
  end

  // Engine reads the bank register directly
  assign o_eng_rdata = bank_rdata;

  buf_read_return u_buf_read_return (
    .xclk          (xclk),
    .i_arst_n      (i_arst_n),
    .i_rd_tag      (rd_tag),
    .i_bank_rdata  (bank_rdata),
    .o_host_rdata  (o_host_rdata),
    .o_host_rvalid (o_host_rvalid),
    .o_host_err    (o_host_err)
  );

endmodule

`default_nettype wire

// File: tb/tb_npu_buf_sys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_npu_buf_sys;

  import buf_cfg_pkg::*;
  import buf_bus_pkg::*;

  // Expected host response
  typedef struct packed {
    logic      err;
    buf_data_t data;
  } host_exp_t;

  logic                xclk;
  logic                arst_n;
  logic                host_en;
  host_req_t           host_req;
  buf_data_t           host_rdata;
  logic                host_rvalid;
  logic                host_err;
  buf_req_t            eng_req   [NUM_BUFS];
  buf_data_t           eng_rdata [NUM_BUFS];

  int                  seed;
  buf_data_t           model_mem [NUM_BUFS][NUM_WORDS];
  host_exp_t           exp_q [$];
  logic [NUM_BUFS-1:0] eng_pend;
  buf_data_t           eng_exp [NUM_BUFS];

  npu_buf_sys u_npu_buf_sys (
    .xclk          (xclk),
    .i_arst_n      (arst_n),
    .i_host_en     (host_en),
    .i_host_req    (host_req),
    .o_host_rdata  (host_rdata),
    .o_host_rvalid (host_rvalid),
    .o_host_err    (host_err),
    .i_eng_req     (eng_req),
    .o_eng_rdata   (eng_rdata)
  );

  initial begin
    xclk = 1'b0;
    forever #5 xclk = ~xclk;
  end

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic buf_data_t rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  // Writes never carry an empty strobe
  function automatic buf_strb_t rand_strb();
    buf_strb_t s;
    s = buf_strb_t'($random(seed));
    if (s == '0) begin
      s = buf_strb_t'(1);
    end
    return s;
  endfunction

  // A set strobe bit replaces that byte
  function automatic buf_data_t merge_bytes(input buf_data_t old_d, input buf_data_t new_d,
                                            input buf_strb_t strb);
    buf_data_t res;
    res = old_d;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_d[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // Start pattern from bank and word together
  function automatic buf_data_t fill_word(input int b, input int w);
    return {16'hc0de ^ 16'(b), 16'(w), 16'(b * NUM_WORDS + w), ~16'(w) ^ 16'(b << 8)};
  endfunction

  task automatic host_access(input bank_idx_t bank, input word_addr_t word, input logic we,
                             input buf_data_t data, input buf_strb_t strb);
    host_req.cs    = 1'b1;
    host_req.we    = we;
    host_req.addr  = {bank, word};
    host_req.wdata = data;
    host_req.strb  = strb;
    if (int'(bank) >= NUM_BUFS) begin
      exp_q.push_back('{err: 1'b1, data: '0});  // Reads and writes alike
    end else if (we) begin
      model_mem[bank][word] = merge_bytes(model_mem[bank][word], data, strb);
    end else begin
      exp_q.push_back('{err: 1'b0, data: model_mem[bank][word]});
    end
  endtask

  task automatic eng_access(input bank_idx_t bank, input word_addr_t word, input logic we,
                            input buf_data_t data, input buf_strb_t strb);
    eng_req[bank].cs    = 1'b1;
    eng_req[bank].we    = we;
    eng_req[bank].addr  = word;
    eng_req[bank].wdata = data;
    eng_req[bank].strb  = strb;
    if (!host_en) begin  // Ignored while the host owns the banks
      if (we) begin
        model_mem[bank][word] = merge_bytes(model_mem[bank][word], data, strb);
      end else begin
        eng_pend[bank] = 1'b1;
        eng_exp[bank]  = model_mem[bank][word];
      end
    end
  endtask

  // Check the responses to the request just accepted and go idle
  task automatic cycle();
    host_exp_t e;
    @(posedge xclk);
    #1;
    assert ((host_rvalid || host_err) == (exp_q.size() != 0)) else
      fail_stop($sformatf("[FAIL] %0t: host rvalid %0b err %0b, response expected %0b",
                          $time, host_rvalid, host_err, exp_q.size() != 0));
    if (host_rvalid || host_err) begin
      e = exp_q.pop_front();
      assert (host_err == e.err && host_rvalid == !e.err) else
        fail_stop($sformatf("[FAIL] %0t: host rvalid %0b err %0b, expected err %0b",
                            $time, host_rvalid, host_err, e.err));
      if (!e.err) begin
        assert (host_rdata == e.data) else
          fail_stop($sformatf("[FAIL] %0t: host read data %h, expected %h",
                              $time, host_rdata, e.data));
      end
    end
    for (int b = 0; b < NUM_BUFS; b++) begin
      if (eng_pend[b]) begin
        assert (eng_rdata[b] == eng_exp[b]) else
          fail_stop($sformatf("[FAIL] %0t: engine bank %0d read %h, expected %h",
                              $time, b, eng_rdata[b], eng_exp[b]));
      end
    end
    eng_pend  = '0;
    host_req  = '0;
    for (int b = 0; b < NUM_BUFS; b++) begin
      eng_req[b] = '0;
    end
  endtask

  task automatic readback_all();
    for (int b = 0; b < NUM_BUFS; b++) begin
      for (int w = 0; w < NUM_WORDS; w++) begin
        host_access(bank_idx_t'(b), word_addr_t'(w), 1'b0, '0, '0);
        cycle();
      end
    end
  endtask

  task automatic random_host_ops(input int count, input logic bad_bank, input logic rd_only);
    bank_idx_t bank;
    logic      we;
    for (int i = 0; i < count; i++) begin
      if (bad_bank) begin
        bank = bank_idx_t'(NUM_BUFS + rand_below((1 << BANK_IDX_W) - NUM_BUFS));
      end else begin
        bank = bank_idx_t'(rand_below(NUM_BUFS));
      end
      we = !rd_only && (rand_below(2) == 1);
      host_access(bank, word_addr_t'(rand_below(NUM_WORDS)), we, rand_data(), rand_strb());
      cycle();
    end
  endtask

  task automatic random_eng_ops(input int count, input logic wr_only);
    int op;
    for (int i = 0; i < count; i++) begin
      for (int b = 0; b < NUM_BUFS; b++) begin
        op = rand_below(3);  // 0 idle, 1 read, 2 write
        if (wr_only && op == 1) begin
          op = 2;
        end
        if (op != 0) begin
          eng_access(bank_idx_t'(b), word_addr_t'(rand_below(NUM_WORDS)), op == 2,
                     rand_data(), rand_strb());
        end
      end
      cycle();
    end
  endtask

  initial begin
    seed      = 32'ha9733327;
    arst_n    = 1'b0;
    host_en   = 1'b0;
    host_req  = '0;
    eng_pend  = '0;
    for (int b = 0; b < NUM_BUFS; b++) begin
      eng_req[b] = '0;
      eng_exp[b] = '0;
    end

    for (int i = 0; i < 10; i++) begin
      @(posedge xclk);
      #1;
      assert (!host_rvalid && !host_err) else
        fail_stop($sformatf("[FAIL] %0t: host pulse raised during reset", $time));
    end
    arst_n = 1'b1;

    // Quiet outputs before the first request
    for (int i = 0; i < 5; i++) begin
      cycle();
    end

    host_en = 1'b1;
    for (int b = 0; b < NUM_BUFS; b++) begin
      for (int w = 0; w < NUM_WORDS; w++) begin
        host_access(bank_idx_t'(b), word_addr_t'(w), 1'b1, fill_word(b, w), '1);
        cycle();
      end
    end
    random_host_ops(200, 1'b0, 1'b0);
    random_host_ops(32, 1'b0, 1'b1);  // Back to back reads
    random_host_ops(24, 1'b1, 1'b0);  // Out of range banks
    readback_all();

    // Engine takes over and reads the host data first
    host_en = 1'b0;
    for (int w = 0; w < NUM_WORDS; w++) begin
      for (int b = 0; b < NUM_BUFS; b++) begin
        eng_access(bank_idx_t'(b), word_addr_t'(w), 1'b0, '0, '0);
      end
      cycle();
    end
    random_eng_ops(200, 1'b0);

    // Engine writes while the host owns the banks must not land
    host_en = 1'b1;
    random_eng_ops(60, 1'b1);
    readback_all();

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
rtl/buf_cfg_pkg.sv
rtl/buf_bus_pkg.sv
rtl/buf_addr_decode.sv
rtl/buf_bank.sv
rtl/buf_read_return.sv
rtl/npu_buf_sys.sv
tb/tb_npu_buf_sys.sv

// File: Makefile
# Verilator flow for the shared NPU buffer system

VERILATOR   ?= verilator
TOP         ?= tb_npu_buf_sys
FLIST       ?= flist.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# The binary exits non-zero when the testbench stops on $fatal
sim:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
